// File: testbench/synth_testdata.txt
# key wsel level period max min
# wsel 0 tri, 1 square, 2 saw, 3 sine; max and min are wout peaks
15 0 0 2108 7936 -7936
12 0 1 2480 3968 -3968
9 0 2 2976 1984 -1984
14 0 3 2232 992 -992
13 1 0 2356 7936 -7936
15 1 1 2108 3968 -3968
11 1 2 2604 1984 -1984
10 1 3 2728 992 -992
15 2 0 2079 7936 -7936
14 2 1 2205 3968 -3968
12 2 2 2457 1984 -1984
8 2 3 3087 992 -992
14 3 0 2232 7936 -7936
13 3 1 2356 3968 -3968
11 3 2 2604 1984 -1984
0 3 3 4960 992 -992

// File: files.f
verilog/synth_pkg.sv
verilog/sine_rom.sv
verilog/note_decode.sv
verilog/wave_gen.sv
verilog/wave_out.sv
verilog/synth_voice_top.sv
testbench/tb_synth_voice.sv

// File: Bender.yml
package:
  name: synth_voice

sources:
  # voice rtl, package first
  - files:
      - verilog/synth_pkg.sv
      - verilog/sine_rom.sv
      - verilog/note_decode.sv
      - verilog/wave_gen.sv
      - verilog/wave_out.sv
      - verilog/synth_voice_top.sv
  # simulation only
  - target: test
    files:
      - testbench/tb_synth_voice.sv

// File: testbench/tb_synth_voice.sv
`timescale 1ns/1ns

module tb_synth_voice;

   logic                 clk;
   logic                 rstn;
   logic                 key_on;
   synth_pkg::key_t      key;
   logic                 key_off;
   synth_pkg::wsel_t     wsel;
   synth_pkg::level_t    level;
   synth_pkg::sample_t   wout;
   logic                 sample_strobe;

   int       vec_key[$];
   int       vec_wsel[$];
   int       vec_level[$];
   int       vec_period[$];
   int       vec_max[$];
   int       vec_min[$];
   int       errors;
   int       checks;
   longint   watch_ns;

   synth_voice_top dut
   (
      .clk           (clk),
      .rstn          (rstn),
      .key_on        (key_on),
      .key           (key),
      .key_off       (key_off),
      .wsel          (wsel),
      .level         (level),
      .wout          (wout),
      .sample_strobe (sample_strobe)
   );

   always #2 clk = ~clk;                         // 4 ns period

   // one clock, then the drive and sample point just after the edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic load_vectors(output bit ok);
      int                 fd;
      int                 n;
      int                 k;
      int                 w;
      int                 l;
      int                 p;
      int                 mx;
      int                 mn;
      longint             total;
      logic [8*256-1:0]   line_buf;
      ok = 1'b0;
      total = 0;
      fd = $fopen("testbench/synth_testdata.txt", "r");
      if (fd == 0)
         $display("cannot open testbench/synth_testdata.txt");
      else
      begin
         while (!$feof(fd))
         begin
            line_buf = '0;
            n = $fgets(line_buf, fd);
            // comment and blank lines give fewer than six fields
            if (n > 0 && $sscanf(line_buf, "%d %d %d %d %d %d", k, w, l, p, mx, mn) == 6)
            begin
               vec_key.push_back(k);
               vec_wsel.push_back(w);
               vec_level.push_back(l);
               vec_period.push_back(p);
               vec_max.push_back(mx);
               vec_min.push_back(mn);
               total += p;
            end
         end
         $fclose(fd);
         if (vec_key.size() == 0)
            $display("no test vectors found in testbench/synth_testdata.txt");
         else
         begin
            ok = 1'b1;
            watch_ns = (total * 3 + 5000) * 4;   // three periods per line plus slack
         end
      end
   endtask

   task automatic check_quiet(input int n, input string what);
      int i;
      for (i = 0; i < n; i++)
      begin
         checks++;
         if (wout !== '0 || sample_strobe !== 1'b0)
         begin
            errors++;
            $display("Error at %0t: %s, wout %0d strobe %b where silence is expected",
                     $time, what, wout, sample_strobe);
         end
         next_cycle();
      end
   endtask

   task automatic run_line(input int idx);
      int   exp_strobes;
      int   prev;
      int   cur;
      int   cycles;
      int   wmax;
      int   wmin;
      int   strobes;
      bit   found;
      bit   done;
      exp_strobes = (vec_wsel[idx] == 2) ? 63 : 124;   // sawtooth has one jump step
      wsel   = synth_pkg::wsel_t'(vec_wsel[idx]);
      level  = synth_pkg::level_t'(vec_level[idx]);
      key    = synth_pkg::key_t'(vec_key[idx]);
      key_on = 1'b1;
      next_cycle();
      key_on = 1'b0;
      // settle on the first rising zero crossing of the new note
      found  = 1'b0;
      cycles = 0;
      prev   = wout;
      while (!found && cycles < 2 * vec_period[idx])
      begin
         next_cycle();
         cycles++;
         cur   = wout;
         found = (prev < 0) && (cur >= 0);
         prev  = cur;
      end
      if (!found)
      begin
         errors++;
         $display("line %0d: wout never crossed zero going up within two periods", idx);
      end
      else
      begin
         // one period, from this crossing up to the next
         wmax    = prev;
         wmin    = prev;
         strobes = sample_strobe ? 1 : 0;
         cycles  = 0;
         done    = 1'b0;
         while (!done && cycles < 2 * vec_period[idx])
         begin
            next_cycle();
            cycles++;
            cur = wout;
            if (prev < 0 && cur >= 0)
               done = 1'b1;
            else
            begin
               if (cur > wmax)
                  wmax = cur;
               if (cur < wmin)
                  wmin = cur;
               if (sample_strobe)
                  strobes++;
            end
            prev = cur;
         end
         checks += 4;
         if (!done)
         begin
            errors++;
            $display("line %0d: second rising crossing missing after two periods", idx);
         end
         if (cycles != vec_period[idx])
         begin
            errors++;
            $display("Error at %0t: line %0d period %0d, expected %0d",
                     $time, idx, cycles, vec_period[idx]);
         end
         if (wmax != vec_max[idx])
         begin
            errors++;
            $display("Error at %0t: line %0d maximum %0d, expected %0d",
                     $time, idx, wmax, vec_max[idx]);
         end
         if (wmin != vec_min[idx])
         begin
            errors++;
            $display("Error at %0t: line %0d minimum %0d, expected %0d",
                     $time, idx, wmin, vec_min[idx]);
         end
         if (strobes != exp_strobes)
         begin
            errors++;
            $display("Error at %0t: line %0d strobe count %0d, expected %0d",
                     $time, idx, strobes, exp_strobes);
         end
      end
      key_off = 1'b1;
      next_cycle();
      key_off = 1'b0;
      next_cycle();
      next_cycle();                               // third edge after key_off
      check_quiet(20, "after key_off");
   endtask

   initial
   begin
      bit ok;
      int idx;
      clk      = 1'b0;
      rstn     = 1'b0;
      key_on   = 1'b0;
      key      = '0;
      key_off  = 1'b0;
      wsel     = synth_pkg::WAVE_TRI;
      level    = '0;
      errors   = 0;
      checks   = 0;
      watch_ns = 0;
      load_vectors(ok);
      if (ok)
      begin
         repeat (5) @(posedge clk);
         #1;
         rstn = 1'b1;
         check_quiet(50, "idle after reset");
         for (idx = 0; idx < vec_key.size(); idx++)
            run_line(idx);
         // keys past the table end start no note
         // square would put a full scale sample on wout at once if one did
         wsel   = synth_pkg::WAVE_SQU;
         level  = '0;
         key    = synth_pkg::key_t'(synth_pkg::NOTE_COUNT);
         key_on = 1'b1;
         next_cycle();
         key_on = 1'b0;
         check_quiet(50, "after key_on with key NOTE_COUNT");
         key    = 7'd127;
         key_on = 1'b1;
         next_cycle();
         key_on = 1'b0;
         check_quiet(50, "after key_on with key 127");
      end
      else
         errors++;
      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

   // watchdog, armed once the vectors give the run length
   initial
   begin
      wait (watch_ns != 0);
      #(watch_ns);
      $display("watchdog expired at %0t with %0d errors, the run did not finish",
               $time, errors);
      $display("Test FAILED");
      $finish;
   end

endmodule

// File: verilog/synth_voice_top.sv
`timescale 1ns/1ns

module synth_voice_top
(
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 key_on,
   input  synth_pkg::key_t      key,
   input  logic                 key_off,
   input  synth_pkg::wsel_t     wsel,
   input  synth_pkg::level_t    level,
   output synth_pkg::sample_t   wout,
   output logic                 sample_strobe
);

   synth_pkg::step_t   step_thr;
   logic               note_active;
   synth_pkg::wave_t   wave_tri;
   synth_pkg::wave_t   wave_saw;
   synth_pkg::wave_t   wave_squ;
   synth_pkg::wave_t   sine_mag;
   logic               sine_neg;
   logic               wave_valid;
   logic               step_tick;

   note_decode u_decode
   (
      .clk         (clk),
      .rstn        (rstn),
      .key_on      (key_on),
      .key         (key),
      .key_off     (key_off),
      .wsel        (wsel),
      .step_thr    (step_thr),
      .note_active (note_active)
   );

   wave_gen u_gen
   (
      .clk         (clk),
      .rstn        (rstn),
      .step_thr    (step_thr),
      .note_active (note_active),
      .wsel        (wsel),
      .wave_tri    (wave_tri),
      .wave_saw    (wave_saw),
      .wave_squ    (wave_squ),
      .sine_mag    (sine_mag),
      .sine_neg    (sine_neg),
      .wave_valid  (wave_valid),
      .step_tick   (step_tick)
   );

   wave_out u_out
   (
      .clk           (clk),
      .rstn          (rstn),
      .wsel          (wsel),
      .level         (level),
      .wave_tri      (wave_tri),
      .wave_saw      (wave_saw),
      .wave_squ      (wave_squ),
      .sine_mag      (sine_mag),
      .sine_neg      (sine_neg),
      .wave_valid    (wave_valid),
      .step_tick     (step_tick),
      .wout          (wout),
      .sample_strobe (sample_strobe)
   );

endmodule

// File: verilog/wave_out.sv
`timescale 1ns/1ns

module wave_out
(
   input  logic                 clk,
   input  logic                 rstn,
   input  synth_pkg::wsel_t     wsel,
   input  synth_pkg::level_t    level,
   input  synth_pkg::wave_t     wave_tri,
   input  synth_pkg::wave_t     wave_saw,
   input  synth_pkg::wave_t     wave_squ,
   input  synth_pkg::wave_t     sine_mag,
   input  logic                 sine_neg,
   input  logic                 wave_valid,
   input  logic                 step_tick,
   output synth_pkg::sample_t   wout,
   output logic                 sample_strobe
);

   synth_pkg::wave_t     sine_val;
   synth_pkg::wave_t     wave_sel;
   synth_pkg::sample_t   wave_ext;
   synth_pkg::sample_t   wave_scaled;
   synth_pkg::sample_t   wave_atten;

   assign sine_val = sine_neg ? -sine_mag : sine_mag;   // unfold lower half

   always_comb
   begin
      case (wsel)
         synth_pkg::WAVE_TRI: wave_sel = wave_tri;
         synth_pkg::WAVE_SQU: wave_sel = wave_squ;
         synth_pkg::WAVE_SAW: wave_sel = wave_saw;
         synth_pkg::WAVE_SIN: wave_sel = sine_val;
         default:             wave_sel = wave_tri;
      endcase
   end

   assign wave_ext    = wave_sel;                          // sign extend
   assign wave_scaled = wave_ext <<< synth_pkg::OUT_SHIFT;
   assign wave_atten  = wave_scaled >>> level;             // keeps the sign

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wout          <= '0;
         sample_strobe <= 1'b0;
      end
      else
      begin
         wout          <= wave_valid ? wave_atten : '0;
         sample_strobe <= step_tick && wave_valid;
      end
   end

   // output goes silent one cycle after the waves stop being valid
   a_silent_out : assert property (@(posedge clk) disable iff (!rstn)
      !wave_valid |=> (wout == '0));

endmodule

// File: verilog/wave_gen.sv
`timescale 1ns/1ns

module wave_gen
(
   input  logic                clk,
   input  logic                rstn,
   input  synth_pkg::step_t    step_thr,
   input  logic                note_active,
   input  synth_pkg::wsel_t    wsel,
   output synth_pkg::wave_t    wave_tri,
   output synth_pkg::wave_t    wave_saw,
   output synth_pkg::wave_t    wave_squ,
   output synth_pkg::wave_t    sine_mag,
   output logic                sine_neg,
   output logic                wave_valid,
   output logic                step_tick
);

   synth_pkg::step_t       step_cnt;
   logic                   step_tc;
   synth_pkg::wave_t       phase;
   logic                   phase_down;          // 1 while the triangle is falling
   logic                   is_saw;
   logic                   squ_high;
   synth_pkg::sine_adx_t   sine_adx;
   logic                   sine_en;

   assign is_saw = (wsel == synth_pkg::WAVE_SAW);

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wave_valid <= 1'b0;
         step_tick  <= 1'b0;
      end
      else
      begin
         wave_valid <= note_active;
         step_tick  <= step_tc && note_active;
      end
   end

   // step counter, wraps after step_thr cycles
   assign step_tc = (step_cnt >= (step_thr - 16'd1));

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
         step_cnt <= '0;
      else if (!note_active || step_tc)
         step_cnt <= '0;
      else
         step_cnt <= step_cnt + 16'd1;
   end

   // phase counter shared by triangle and sawtooth
   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         phase      <= '0;
         phase_down <= 1'b0;
      end
      else if (!note_active)
      begin
         phase      <= '0;
         phase_down <= 1'b0;
      end
      else if (step_tc)
      begin
         if (phase_down)
         begin
            if (phase == synth_pkg::WAVE_MIN)
            begin
               phase      <= phase + 6'sd1;
               phase_down <= 1'b0;
            end
            else
               phase <= phase - 6'sd1;
         end
         else if (phase == synth_pkg::WAVE_MAX)
         begin
            if (is_saw)
               phase <= -phase;                 // jump back to WAVE_MIN
            else
            begin
               phase      <= phase - 6'sd1;
               phase_down <= 1'b1;
            end
         end
         else
            phase <= phase + 6'sd1;
      end
   end

   // square goes high as the phase reaches the top, low as it reaches the bottom
   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
         squ_high <= 1'b0;
      else if (!note_active)
         squ_high <= 1'b0;
      else if (step_tc && !phase_down && (phase == synth_pkg::SQU_UP))
         squ_high <= 1'b1;
      else if (step_tc && phase_down && (phase == synth_pkg::SQU_DOWN))
         squ_high <= 1'b0;
   end

   // registered waves, one cycle behind the phase like the sine rom
   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wave_tri <= '0;
         wave_saw <= '0;
         wave_squ <= '0;
         sine_neg <= 1'b0;
      end
      else
      begin
         wave_tri <= note_active ? phase : '0;
         wave_saw <= note_active ? phase : '0;
         if (!note_active)
            wave_squ <= '0;
         else
            wave_squ <= squ_high ? synth_pkg::WAVE_MAX : synth_pkg::WAVE_MIN;
         sine_neg <= phase[synth_pkg::WAVE_W-1];   // sign travels with the rom read
      end
   end

   // fold the phase into a quarter-wave address
   assign sine_adx = phase[synth_pkg::WAVE_W-1] ? (~phase[4:0] + 5'd1) : phase[4:0];
   assign sine_en  = note_active;

   sine_rom u_rom
   (
      .clk  (clk),
      .rstn (rstn),
      .en   (sine_en),
      .adx  (sine_adx),
      .data (sine_mag)
   );

   a_phase_range : assert property (@(posedge clk) disable iff (!rstn)
      (phase >= synth_pkg::WAVE_MIN) && (phase <= synth_pkg::WAVE_MAX));

endmodule

// File: verilog/note_decode.sv
`timescale 1ns/1ns

module note_decode
(
   input  logic                clk,
   input  logic                rstn,
   input  logic                key_on,
   input  synth_pkg::key_t     key,
   input  logic                key_off,
   input  synth_pkg::wsel_t    wsel,
   output synth_pkg::step_t    step_thr,
   output logic                note_active
);

   synth_pkg::key_t   key_q;
   synth_pkg::step_t  tri_thr;
   synth_pkg::step_t  saw_thr;
   logic              key_valid;

   assign key_valid = key_on && (key < synth_pkg::NOTE_COUNT);   // out of table keys dropped

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         key_q       <= '0;
         note_active <= 1'b0;
      end
      else if (key_valid)
      begin
         key_q       <= key;
         note_active <= 1'b1;
      end
      else if (key_off)
      begin
         note_active <= 1'b0;
      end
   end

   // triangle, square and sine column, 124 steps per period
   always_comb
   begin
      case (key_q)
         7'd0:    tri_thr = 16'd40;
         7'd1:    tri_thr = 16'd38;
         7'd2:    tri_thr = 16'd36;
         7'd3:    tri_thr = 16'd34;
         7'd4:    tri_thr = 16'd32;
         7'd5:    tri_thr = 16'd30;
         7'd6:    tri_thr = 16'd28;
         7'd7:    tri_thr = 16'd27;
         7'd8:    tri_thr = 16'd25;
         7'd9:    tri_thr = 16'd24;
         7'd10:   tri_thr = 16'd22;
         7'd11:   tri_thr = 16'd21;
         7'd12:   tri_thr = 16'd20;
         7'd13:   tri_thr = 16'd19;
         7'd14:   tri_thr = 16'd18;
         7'd15:   tri_thr = 16'd17;
         default: tri_thr = '0;
      endcase
   end

   // sawtooth column, about twice as long since a period is only 63 steps
   always_comb
   begin
      case (key_q)
         7'd0:    saw_thr = 16'd79;
         7'd1:    saw_thr = 16'd75;
         7'd2:    saw_thr = 16'd71;
         7'd3:    saw_thr = 16'd67;
         7'd4:    saw_thr = 16'd63;
         7'd5:    saw_thr = 16'd59;
         7'd6:    saw_thr = 16'd55;
         7'd7:    saw_thr = 16'd53;
         7'd8:    saw_thr = 16'd49;
         7'd9:    saw_thr = 16'd47;
         7'd10:   saw_thr = 16'd43;
         7'd11:   saw_thr = 16'd41;
         7'd12:   saw_thr = 16'd39;
         7'd13:   saw_thr = 16'd37;
         7'd14:   saw_thr = 16'd35;
         7'd15:   saw_thr = 16'd33;
         default: saw_thr = '0;
      endcase
   end

   assign step_thr = (wsel == synth_pkg::WAVE_SAW) ? saw_thr : tri_thr;

   // a held note always points at a real table row
   a_thr_nonzero : assert property (@(posedge clk) disable iff (!rstn)
      note_active |-> (step_thr != '0));

endmodule

// File: verilog/sine_rom.sv
`timescale 1ns/1ns

module sine_rom
(
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   en,
   input  synth_pkg::sine_adx_t   adx,
   output synth_pkg::wave_t       data
);

   // quarter sine, 0 to 90 degrees over 32 points, amplitude 31
   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         data <= '0;
      end
      else if (en)
      begin
         case (adx)
            5'd0:  data <= 6'sd0;
            5'd1:  data <= 6'sd2;
            5'd2:  data <= 6'sd3;
            5'd3:  data <= 6'sd5;
            5'd4:  data <= 6'sd6;
            5'd5:  data <= 6'sd8;
            5'd6:  data <= 6'sd9;
            5'd7:  data <= 6'sd11;
            5'd8:  data <= 6'sd12;
            5'd9:  data <= 6'sd14;
            5'd10: data <= 6'sd15;
            5'd11: data <= 6'sd16;
            5'd12: data <= 6'sd18;
            5'd13: data <= 6'sd19;
            5'd14: data <= 6'sd20;
            5'd15: data <= 6'sd21;
            5'd16: data <= 6'sd22;
            5'd17: data <= 6'sd24;
            5'd18: data <= 6'sd25;
            5'd19: data <= 6'sd25;
            5'd20: data <= 6'sd26;
            5'd21: data <= 6'sd27;
            5'd22: data <= 6'sd28;
            5'd23: data <= 6'sd28;
            5'd24: data <= 6'sd29;
            5'd25: data <= 6'sd30;
            5'd26: data <= 6'sd30;
            5'd27: data <= 6'sd30;
            5'd28: data <= 6'sd31;
            5'd29: data <= 6'sd31;
            5'd30: data <= 6'sd31;
            5'd31: data <= 6'sd31;            // peak
            default: data <= 6'sd0;
         endcase
      end
   end

endmodule

// File: verilog/synth_pkg.sv
package synth_pkg;

   // field widths
   localparam int KEY_W      = 7;
   localparam int STEP_W     = 16;
   localparam int WAVE_W     = 6;
   localparam int SINE_ADX_W = 5;
   localparam int SAMPLE_W   = 14;
   localparam int LEVEL_W    = 2;

   // number of rows in the frequency table
   localparam int NOTE_COUNT = 16;

   typedef logic [KEY_W-1:0] key_t;                 // note index
   typedef logic [STEP_W-1:0] step_t;               // clock cycles per phase step
   typedef logic signed [WAVE_W-1:0] wave_t;        // raw waveform sample
   typedef logic [SINE_ADX_W-1:0] sine_adx_t;       // quarter-wave rom address
   typedef logic signed [SAMPLE_W-1:0] sample_t;    // output word
   typedef logic [LEVEL_W-1:0] level_t;             // attenuation as right shift

   typedef enum logic [1:0]
   {
      WAVE_TRI = 2'b00,
      WAVE_SQU = 2'b01,
      WAVE_SAW = 2'b10,
      WAVE_SIN = 2'b11
   } wsel_t;

   // wave limits, symmetric so negation stays in range
   localparam wave_t WAVE_MAX = 6'sd31;
   localparam wave_t WAVE_MIN = -6'sd31;

   // square switches one step before the peaks
   localparam wave_t SQU_UP   = 6'sd30;
   localparam wave_t SQU_DOWN = -6'sd30;

   // places a wave sample in the top bits of the output word
   localparam int OUT_SHIFT = 8;

endpackage
